// ==== Bender.yml ====
package:
  name: cpu_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - issue_if.sv
      - fetch_stage.sv
      - register_file.sv
      - decode_stage.sv
      - alu_stage.sv
      - mul_pipe.sv
      - cpu_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_checker.sv
      - tb_cpu.sv

// ==== alu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module alu_stage import cpu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  issue_if.unit                  iss,
  output logic                   res_valid_o,
  output logic [`CPU_REG_AW-1:0] res_rd_o,
  output logic [`CPU_XLEN-1:0]   res_data_o,
  output logic [`CPU_N_REGS-1:0] dest_busy_o
);

  logic [`CPU_XLEN-1:0] result;

  always_comb begin
    case (iss.op)
      ALU_ADD: result = iss.a + iss.b;
      ALU_SUB: result = iss.a - iss.b;
      ALU_AND: result = iss.a & iss.b;
      ALU_OR:  result = iss.a | iss.b;
      ALU_XOR: result = iss.a ^ iss.b;
      ALU_SLL: result = iss.a << iss.b[4:0];
      ALU_SRL: result = iss.a >> iss.b[4:0];
      default: result = iss.a + iss.b;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= iss.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    res_rd_o   <= iss.rd;
    res_data_o <= result;
  end

  // Pending only while the op sits at the input
  always_comb begin
    dest_busy_o = '0;
    if (iss.valid && iss.rd != '0) begin
      dest_busy_o[iss.rd] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_checker import cpu_pkg::*; #(
  parameter int N_CHECK = 200
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic [`CPU_XLEN-1:0]   wb_adr_i,
  input  logic [`CPU_XLEN-1:0]   wb_dat_i,
  input  logic                   wb_ack_i,
  input  logic                   retire_valid_i,
  input  logic [`CPU_REG_AW-1:0] retire_rd_i,
  input  logic [`CPU_XLEN-1:0]   retire_data_i,
  output logic                   done_o,
  output int                     mismatches_o,
  output int                     failures_o,
  output int                     retired_o
);

  logic [`CPU_XLEN-1:0]   model_regs [`CPU_N_REGS];
  instr_t                 fetched_q [$];
  instr_t                 w;
  logic [`CPU_REG_AW-1:0] exp_rd;
  logic [`CPU_XLEN-1:0]   exp_data;
  logic [`CPU_XLEN-1:0]   next_adr;
  logic                   acked_q;
  logic                   pending_q;
  logic [`CPU_XLEN-1:0]   pend_adr;
  int                     mismatches;
  int                     failures;
  int                     retired;

  function automatic logic [`CPU_XLEN-1:0] model_result(instr_t iw, logic [`CPU_XLEN-1:0] a,
                                                        logic [`CPU_XLEN-1:0] b);
    logic [`CPU_XLEN-1:0] imm;
    imm = {{(`CPU_XLEN-12){iw.i.imm12[11]}}, iw.i.imm12};
    if (iw.r.opcode == `CPU_OP_IMM) begin
      case (iw.i.funct3)
        `CPU_F3_XOR: return a ^ imm;
        `CPU_F3_OR:  return a | imm;
        `CPU_F3_AND: return a & imm;
        default:     return a + imm;
      endcase
    end
    case (iw.r.funct3)
      `CPU_F3_ADD: begin
        if (iw.r.funct7 == `CPU_F7_MUL) return a * b;
        if (iw.r.funct7 == `CPU_F7_SUB) return a - b;
        return a + b;
      end
      `CPU_F3_SLL: return a << b[4:0];
      `CPU_F3_SRL: return a >> b[4:0];
      `CPU_F3_XOR: return a ^ b;
      `CPU_F3_OR:  return a | b;
      `CPU_F3_AND: return a & b;
      default:     return a + b;
    endcase
  endfunction

  // ========================================
  // Fetch order and retire comparison
  // ========================================
  always @(posedge clk_i) begin
    if (!rst_i) begin
      for (int r = 0; r < `CPU_N_REGS; r++) begin
        model_regs[r] = '0;
      end
      fetched_q.delete();
      next_adr   = `CPU_RESET_PC;
      acked_q    = 1'b0;
      pending_q  = 1'b0;
      mismatches = 0;
      failures   = 0;
      retired    = 0;
    end else begin
      if (retire_valid_i === 1'b1 && retired < N_CHECK) begin
        if (fetched_q.size() == 0) begin
          failures++;
          $display("At %0t an instruction retired before any was fetched", $time);
        end else begin
          w        = fetched_q.pop_front();
          exp_rd   = w.r.rd;
          exp_data = model_result(w, model_regs[w.r.rs1], model_regs[w.r.rs2]);
          if (retire_rd_i !== exp_rd) begin
            mismatches++;
            $display("MISMATCH at %0t: retire_rd_o got %0d expected %0d",
                     $time, retire_rd_i, exp_rd);
          end
          if (retire_data_i !== exp_data) begin
            mismatches++;
            $display("MISMATCH at %0t: retire_data_o got %h expected %h",
                     $time, retire_data_i, exp_data);
          end
          // x0 retires but keeps reading zero
          if (exp_rd != '0) begin
            model_regs[exp_rd] = exp_data;
          end
        end
        retired++;
      end
      // Wishbone classic master behavior
      if (wb_cyc_i !== wb_stb_i) begin
        failures++;
        $display("At %0t wb_cyc_o and wb_stb_o differ", $time);
      end
      if (acked_q && wb_cyc_i !== 1'b0) begin
        failures++;
        $display("At %0t wb_cyc_o did not drop in the cycle after an ack", $time);
      end
      if (pending_q && (wb_cyc_i !== 1'b1 || wb_adr_i !== pend_adr)) begin
        failures++;
        $display("At %0t a fetch request was dropped or moved before its ack", $time);
      end
      if (wb_cyc_i && wb_stb_i && wb_ack_i) begin
        if (wb_adr_i !== next_adr) begin
          mismatches++;
          $display("MISMATCH at %0t: wb_adr_o got %h expected %h", $time, wb_adr_i, next_adr);
        end
        fetched_q.push_back(wb_dat_i);
        next_adr = next_adr + `CPU_XLEN'(4);
      end
      acked_q   = wb_cyc_i === 1'b1 && wb_ack_i === 1'b1;
      pending_q = wb_cyc_i === 1'b1 && wb_ack_i !== 1'b1;
      pend_adr  = wb_adr_i;
    end
  end

  assign done_o       = retired >= N_CHECK;
  assign mismatches_o = mismatches;
  assign failures_o   = failures;
  assign retired_o    = retired;

endmodule

`default_nettype wire

// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath sizes
`define CPU_XLEN        32
`define CPU_REG_AW      5
`define CPU_N_REGS      32
`define CPU_MUL_STAGES  5
`define CPU_RESET_PC    32'h0000_0000

// Opcodes and function codes
`define CPU_OP_REG      7'b0110011
`define CPU_OP_IMM      7'b0010011
`define CPU_F3_ADD      3'b000
`define CPU_F3_SLL      3'b001
`define CPU_F3_XOR      3'b100
`define CPU_F3_SRL      3'b101
`define CPU_F3_OR       3'b110
`define CPU_F3_AND      3'b111
`define CPU_F7_SUB      7'b0100000
`define CPU_F7_MUL      7'b0000001

`endif

// ==== cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_core import cpu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic [`CPU_XLEN-1:0]   wb_adr_o,
  input  logic [`CPU_XLEN-1:0]   wb_dat_i,
  input  logic                   wb_ack_i,
  output logic                   retire_valid_o,
  output logic [`CPU_REG_AW-1:0] retire_rd_o,
  output logic [`CPU_XLEN-1:0]   retire_data_o
);

  logic                   instr_valid;
  logic                   instr_take;
  instr_t                 instr;
  logic [`CPU_REG_AW-1:0] rs1, rs2;
  logic [`CPU_XLEN-1:0]   rs1_data, rs2_data;
  logic [`CPU_N_REGS-1:0] alu_busy_mask, mul_busy_mask;
  logic                   mul_busy;
  logic                   alu_res_valid, mul_res_valid;
  logic [`CPU_REG_AW-1:0] alu_res_rd, mul_res_rd;
  logic [`CPU_XLEN-1:0]   alu_res_data, mul_res_data;
  logic                   wb_valid;
  logic [`CPU_REG_AW-1:0] wb_rd;
  logic [`CPU_XLEN-1:0]   wb_data;

  issue_if alu_iss ();
  issue_if mul_iss ();

  fetch_stage fetch_stage_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_adr_o(wb_adr_o),
    .instr_take_i(instr_take), .instr_valid_o(instr_valid), .instr_o(instr)
  );

  decode_stage decode_stage_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .instr_valid_i(instr_valid), .instr_i(instr), .instr_take_o(instr_take),
    .rs1_o(rs1), .rs2_o(rs2), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .alu_busy_mask_i(alu_busy_mask), .mul_busy_mask_i(mul_busy_mask),
    .mul_busy_i(mul_busy), .alu_iss(alu_iss), .mul_iss(mul_iss)
  );

  register_file register_file_i (
    .clk_i(clk_i), .rst_i(rst_i), .rs1_i(rs1), .rs2_i(rs2),
    .wr_en_i(wb_valid), .wr_rd_i(wb_rd), .wr_data_i(wb_data),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  alu_stage alu_stage_i (
    .clk_i(clk_i), .rst_i(rst_i), .iss(alu_iss),
    .res_valid_o(alu_res_valid), .res_rd_o(alu_res_rd), .res_data_o(alu_res_data),
    .dest_busy_o(alu_busy_mask)
  );

  mul_pipe mul_pipe_i (
    .clk_i(clk_i), .rst_i(rst_i), .iss(mul_iss),
    .res_valid_o(mul_res_valid), .res_rd_o(mul_res_rd), .res_data_o(mul_res_data),
    .dest_busy_o(mul_busy_mask), .busy_o(mul_busy)
  );

  // ========================================
  // Write-back select
  // ========================================
  // Decode ordering keeps the two units from finishing together
  assign wb_valid = alu_res_valid | mul_res_valid;
  assign wb_rd    = alu_res_valid ? alu_res_rd : mul_res_rd;
  assign wb_data  = alu_res_valid ? alu_res_data : mul_res_data;

  assign retire_valid_o = wb_valid;
  assign retire_rd_o    = wb_rd;
  assign retire_data_o  = wb_data;

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

  // One instruction word, viewed as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0]             funct7;
      logic [`CPU_REG_AW-1:0] rs2;
      logic [`CPU_REG_AW-1:0] rs1;
      logic [2:0]             funct3;
      logic [`CPU_REG_AW-1:0] rd;
      logic [6:0]             opcode;
    } r;
    struct packed {
      logic [11:0]            imm12;
      logic [`CPU_REG_AW-1:0] rs1;
      logic [2:0]             funct3;
      logic [`CPU_REG_AW-1:0] rd;
      logic [6:0]             opcode;
    } i;
  } instr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL
  } alu_op_t;

endpackage

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module decode_stage import cpu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   instr_valid_i,
  input  instr_t                 instr_i,
  output logic                   instr_take_o,
  output logic [`CPU_REG_AW-1:0] rs1_o,
  output logic [`CPU_REG_AW-1:0] rs2_o,
  input  logic [`CPU_XLEN-1:0]   rs1_data_i,
  input  logic [`CPU_XLEN-1:0]   rs2_data_i,
  input  logic [`CPU_N_REGS-1:0] alu_busy_mask_i,
  input  logic [`CPU_N_REGS-1:0] mul_busy_mask_i,
  input  logic                   mul_busy_i,
  issue_if.issuer                alu_iss,
  issue_if.issuer                mul_iss
);

  logic                   is_imm;
  logic                   is_mul;
  logic                   stall;
  logic                   issue;
  logic [`CPU_N_REGS-1:0] busy_mask;
  logic [`CPU_XLEN-1:0]   imm_ext;
  alu_op_t                op_d;
  alu_op_t                op_q;
  logic [`CPU_REG_AW-1:0] rd_q;
  logic [`CPU_XLEN-1:0]   a_q;
  logic [`CPU_XLEN-1:0]   b_q;

  // ========================================
  // Field decode
  // ========================================
  assign is_imm  = instr_i.r.opcode == `CPU_OP_IMM;
  assign is_mul  = !is_imm && instr_i.r.funct7 == `CPU_F7_MUL
                   && instr_i.r.funct3 == `CPU_F3_ADD;
  assign rs1_o   = instr_i.r.rs1;
  assign rs2_o   = is_imm ? '0 : instr_i.r.rs2;  // x0 is never busy
  assign imm_ext = {{(`CPU_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

  always_comb begin
    op_d = ALU_ADD;
    case (instr_i.r.funct3)
      `CPU_F3_ADD: op_d = (!is_imm && instr_i.r.funct7 == `CPU_F7_SUB) ? ALU_SUB : ALU_ADD;
      `CPU_F3_SLL: op_d = is_imm ? ALU_ADD : ALU_SLL;
      `CPU_F3_SRL: op_d = is_imm ? ALU_ADD : ALU_SRL;
      `CPU_F3_XOR: op_d = ALU_XOR;
      `CPU_F3_OR:  op_d = ALU_OR;
      `CPU_F3_AND: op_d = ALU_AND;
      default:     op_d = ALU_ADD;
    endcase
  end

  // ALU ops wait out the multiplier so results retire in order
  assign busy_mask    = alu_busy_mask_i | mul_busy_mask_i;
  assign stall        = busy_mask[rs1_o] | busy_mask[rs2_o] | (!is_mul && mul_busy_i);
  assign issue        = instr_valid_i && !stall;
  assign instr_take_o = issue;

  // ========================================
  // Issue registers
  // ========================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      alu_iss.valid <= 1'b0;
      mul_iss.valid <= 1'b0;
    end else begin
      alu_iss.valid <= issue && !is_mul;
      mul_iss.valid <= issue && is_mul;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      op_q <= op_d;
      rd_q <= instr_i.r.rd;
      a_q  <= rs1_data_i;
      b_q  <= is_imm ? imm_ext : rs2_data_i;
    end
  end

  assign alu_iss.op = op_q;
  assign alu_iss.rd = rd_q;
  assign alu_iss.a  = a_q;
  assign alu_iss.b  = b_q;
  assign mul_iss.op = op_q;
  assign mul_iss.rd = rd_q;
  assign mul_iss.a  = a_q;
  assign mul_iss.b  = b_q;

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module fetch_stage import cpu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [`CPU_XLEN-1:0] wb_dat_i,
  input  logic                 wb_ack_i,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic [`CPU_XLEN-1:0] wb_adr_o,
  input  logic                 instr_take_i,
  output logic                 instr_valid_o,
  output instr_t               instr_o
);

  logic                 cyc_q;
  logic                 held_q;
  logic [`CPU_XLEN-1:0] pc_q;
  instr_t               instr_q;

  // ========================================
  // Bus cycle and PC
  // ========================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      cyc_q  <= 1'b0;
      held_q <= 1'b0;
      pc_q   <= `CPU_RESET_PC;
    end else if (cyc_q) begin
      if (wb_ack_i) begin
        cyc_q  <= 1'b0;
        held_q <= 1'b1;
        pc_q   <= pc_q + `CPU_XLEN'(4);
      end
    end else if (held_q) begin
      // Next request only once decode has the word
      if (instr_take_i) begin
        held_q <= 1'b0;
        cyc_q  <= 1'b1;
      end
    end else begin
      cyc_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cyc_q && wb_ack_i) begin
      instr_q <= wb_dat_i;
    end
  end

  assign wb_cyc_o      = cyc_q;
  assign wb_stb_o      = cyc_q;
  assign wb_adr_o      = pc_q;
  assign instr_valid_o = held_q;
  assign instr_o       = instr_q;

endmodule

`default_nettype wire

// ==== issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

interface issue_if import cpu_pkg::*; ();

  logic                   valid;
  alu_op_t                op;
  logic [`CPU_REG_AW-1:0] rd;
  logic [`CPU_XLEN-1:0]   a;
  logic [`CPU_XLEN-1:0]   b;

  modport issuer (output valid, output op, output rd, output a, output b);

  // Execute units take every issue, so no ready
  modport unit (input valid, input op, input rd, input a, input b);

endinterface

`default_nettype wire

// ==== mul_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module mul_pipe (
  input  logic                   clk_i,
  input  logic                   rst_i,
  issue_if.unit                  iss,
  output logic                   res_valid_o,
  output logic [`CPU_REG_AW-1:0] res_rd_o,
  output logic [`CPU_XLEN-1:0]   res_data_o,
  output logic [`CPU_N_REGS-1:0] dest_busy_o,
  output logic                   busy_o
);

  logic [`CPU_MUL_STAGES-1:0] valid_q;
  logic [`CPU_REG_AW-1:0]     rd_q   [`CPU_MUL_STAGES];
  logic [`CPU_XLEN-1:0]       prod_q [`CPU_MUL_STAGES];
  logic [`CPU_XLEN-1:0]       product;

  // Low half of the product only
  assign product = iss.a * iss.b;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[`CPU_MUL_STAGES-2:0], iss.valid};
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q[0]   <= iss.rd;
    prod_q[0] <= product;
    for (int s = 1; s < `CPU_MUL_STAGES; s++) begin
      rd_q[s]   <= rd_q[s-1];
      prod_q[s] <= prod_q[s-1];
    end
  end

  assign res_valid_o = valid_q[`CPU_MUL_STAGES-1];
  assign res_rd_o    = rd_q[`CPU_MUL_STAGES-1];
  assign res_data_o  = prod_q[`CPU_MUL_STAGES-1];
  assign busy_o      = iss.valid | (|valid_q);

  // Last stage is covered by the regfile bypass
  always_comb begin
    dest_busy_o = '0;
    if (iss.valid) begin
      dest_busy_o[iss.rd] = 1'b1;
    end
    for (int s = 0; s < `CPU_MUL_STAGES - 1; s++) begin
      if (valid_q[s]) begin
        dest_busy_o[rd_q[s]] = 1'b1;
      end
    end
    dest_busy_o[0] = 1'b0;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
cpu_pkg.sv
issue_if.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
alu_stage.sv
mul_pipe.sv
cpu_core.sv
cpu_checker.sv
tb_cpu.sv

// ==== register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module register_file (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [`CPU_REG_AW-1:0] rs1_i,
  input  logic [`CPU_REG_AW-1:0] rs2_i,
  input  logic                   wr_en_i,
  input  logic [`CPU_REG_AW-1:0] wr_rd_i,
  input  logic [`CPU_XLEN-1:0]   wr_data_i,
  output logic [`CPU_XLEN-1:0]   rs1_data_o,
  output logic [`CPU_XLEN-1:0]   rs2_data_o
);

  logic [`CPU_XLEN-1:0] regs_q [`CPU_N_REGS];
  logic                 wr_live;

  // x0 stays zero from reset on
  assign wr_live = wr_en_i && (wr_rd_i != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int r = 0; r < `CPU_N_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (wr_live) begin
      regs_q[wr_rd_i] <= wr_data_i;
    end
  end

  // Same-cycle write bypass
  assign rs1_data_o = (wr_live && wr_rd_i == rs1_i) ? wr_data_i : regs_q[rs1_i];
  assign rs2_data_o = (wr_live && wr_rd_i == rs2_i) ? wr_data_i : regs_q[rs2_i];

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module tb_cpu import cpu_pkg::*; ();

  localparam int N_INSTR         = 200;
  localparam int WATCHDOG_CYCLES = N_INSTR * (`CPU_MUL_STAGES + 8);

  logic                   clk;
  logic                   rst;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic [`CPU_XLEN-1:0]   wb_adr;
  logic [`CPU_XLEN-1:0]   wb_dat;
  logic                   wb_ack;
  logic                   retire_valid;
  logic [`CPU_REG_AW-1:0] retire_rd;
  logic [`CPU_XLEN-1:0]   retire_data;
  logic                   done;
  int                     mismatches;
  int                     failures;
  int                     retired;

  integer                 seed;
  logic [`CPU_XLEN-1:0]   prog [N_INSTR];
  logic                   req_seen;
  int unsigned            ack_wait;

  cpu_core cpu_core_i (
    .clk_i(clk), .rst_i(rst),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_adr_o(wb_adr),
    .wb_dat_i(wb_dat), .wb_ack_i(wb_ack),
    .retire_valid_o(retire_valid), .retire_rd_o(retire_rd), .retire_data_o(retire_data)
  );

  cpu_checker #(.N_CHECK(N_INSTR)) cpu_checker_i (
    .clk_i(clk), .rst_i(rst),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat), .wb_ack_i(wb_ack),
    .retire_valid_i(retire_valid), .retire_rd_i(retire_rd), .retire_data_i(retire_data),
    .done_o(done), .mismatches_o(mismatches), .failures_o(failures), .retired_o(retired)
  );

  // Past the program everything reads as ADDI x0,x0,0
  function automatic logic [`CPU_XLEN-1:0] mem_word(logic [`CPU_XLEN-1:0] adr);
    logic [`CPU_XLEN-1:0] idx;
    idx = adr >> 2;
    if (adr[1:0] == 2'b00 && idx < N_INSTR) begin
      return prog[idx];
    end
    return 32'h0000_0013;
  endfunction

  task automatic build_program();
    instr_t                 w;
    int unsigned            kind;
    int                     n;
    logic [`CPU_REG_AW-1:0] rd;
    logic [`CPU_REG_AW-1:0] rs1;
    logic [`CPU_REG_AW-1:0] rs2;
    logic [`CPU_REG_AW-1:0] last_rd;
    last_rd = '0;
    for (n = 0; n < N_INSTR; n++) begin
      kind = $unsigned($random(seed)) % 14;
      // Few registers, so dependencies and x0 writes come up often
      rd  = `CPU_REG_AW'($unsigned($random(seed)) % 8);
      rs1 = `CPU_REG_AW'($unsigned($random(seed)) % 8);
      rs2 = `CPU_REG_AW'($unsigned($random(seed)) % 8);
      if ($random(seed) & 1) begin
        rs1 = last_rd;
      end
      w = '0;
      if (kind < 4) begin
        w.i.opcode = `CPU_OP_IMM;
        w.i.rd     = rd;
        w.i.rs1    = rs1;
        w.i.imm12  = 12'($random(seed));
        case (kind)
          0: w.i.funct3 = `CPU_F3_ADD;
          1: w.i.funct3 = `CPU_F3_XOR;
          2: w.i.funct3 = `CPU_F3_OR;
          default: w.i.funct3 = `CPU_F3_AND;
        endcase
      end else begin
        w.r.opcode = `CPU_OP_REG;
        w.r.rd     = rd;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        case (kind)
          4: w.r.funct3 = `CPU_F3_ADD;
          5: begin
            w.r.funct3 = `CPU_F3_ADD;
            w.r.funct7 = `CPU_F7_SUB;
          end
          6: w.r.funct3 = `CPU_F3_AND;
          7: w.r.funct3 = `CPU_F3_OR;
          8: w.r.funct3 = `CPU_F3_XOR;
          9: w.r.funct3 = `CPU_F3_SLL;
          10: w.r.funct3 = `CPU_F3_SRL;
          default: begin
            w.r.funct3 = `CPU_F3_ADD;
            w.r.funct7 = `CPU_F7_MUL;
          end
        endcase
      end
      prog[n] = w;
      last_rd = rd;
    end
  endtask

  // ========================================
  // Clock, reset and main sequence
  // ========================================
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    seed     = 32'h3eb3;
    rst      = 1'b0;
    wb_dat   = '0;
    wb_ack   = 1'b0;
    req_seen = 1'b0;
    ack_wait = 0;
    build_program();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    wait (done);
    @(negedge clk);
    $display("Errors: %0d mismatches, %0d other failures, %0d instructions retired",
             mismatches, failures, retired);
    if (mismatches == 0 && failures == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Memory slave, answers after 0 to 3 cycles
  always @(negedge clk) begin
    if (wb_ack) begin
      wb_ack   = 1'b0;
      req_seen = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!req_seen) begin
        req_seen = 1'b1;
        ack_wait = $unsigned($random(seed)) % 4;
      end
      if (ack_wait == 0) begin
        wb_ack = 1'b1;
        wb_dat = mem_word(wb_adr);
      end else begin
        ack_wait--;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles with %0d of %0d instructions retired",
             WATCHDOG_CYCLES, retired, N_INSTR);
    $display("Errors: %0d mismatches, %0d other failures, %0d instructions retired",
             mismatches, failures + 1, retired);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
